/* xgmii_rx_consts.svh */
`ifndef XGMII_RX_CONSTS_SVH
`define XGMII_RX_CONSTS_SVH
`default_nettype none

////////////////////////////////////////
// XGMII control characters

// Start of frame, only ever seen in lane 3
`define XGMII_CTL_START		8'hfb
// Terminate, may land in any lane
`define XGMII_CTL_END		8'hfd
// In-band error from the PCS
`define XGMII_CTL_ERROR		8'hfe
`define XGMII_CTL_IDLE		8'h07

// Remaining preamble bytes plus SFD, lane 3 first
`define XGMII_PREAMBLE_SFD	32'h5555_55d5

////////////////////////////////////////
// Bus geometry

`define XGMII_DATA_W		32
`define XGMII_LANES			4

////////////////////////////////////////
// Ethernet CRC-32, LSB-first form

`define CRC32_POLY			32'hedb8_8320
`define CRC32_INIT			32'hffff_ffff
`define CRC32_XOROUT		32'hffff_ffff

`default_nettype wire
`endif

/* xgmii_pkg.sv */
`include "xgmii_rx_consts.svh"
`default_nettype none

// Types describing one 32-bit XGMII word as seen on the wire
package xgmii_pkg;

	// One flag per lane, bit 3 is the earliest byte
	typedef logic [`XGMII_LANES-1:0] lane_mask_t;

	// Data and control bits of one XGMII word
	// Lane i lives in data[8*i+7:8*i] with its control bit in ctl[i]
	typedef struct packed {
		logic [`XGMII_DATA_W-1:0]	data;
		lane_mask_t					ctl;
	} xgmii_word_t;

	// ctl high means the lane carries a control character
	// ctl low means the lane carries a data byte

endpackage

`default_nettype wire

/* rx_stream_pkg.sv */
`include "xgmii_rx_consts.svh"
`default_nettype none

// Types for the receive stream side and frame tracking
package rx_stream_pkg;

	// Valid bytes in one beat, 0 up to a full word
	typedef logic [2:0] byte_count_t;

	// Byte strobes, bit 0 is the earliest byte
	typedef logic [`XGMII_LANES-1:0] strb_t;

	// Receive framing states
	typedef enum logic [1:0] {
		// Waiting for a start character
		IDLE		= 2'd0,
		// Start seen, expecting the preamble/SFD word
		PREAMBLE	= 2'd1,
		// Payload and FCS until terminate
		BODY		= 2'd2
	} frame_state_t;

endpackage

`default_nettype wire

/* rx_lane_if.sv */
`default_nettype none

// Registered XGMII word plus per-lane control decode
interface rx_lane_if;
	import xgmii_pkg::*;

	logic			valid;
	xgmii_word_t	word;
	// Lane 3 holds the start character
	logic			start_seen;
	// Lanes holding terminate or error characters
	lane_mask_t		end_lanes;
	lane_mask_t		error_lanes;

	modport decoder (
		output valid, word, start_seen, end_lanes, error_lanes
	);

	modport framer (
		input valid, word, start_seen, end_lanes, error_lanes
	);

endinterface

`default_nettype wire

/* rx_beat_if.sv */
`include "xgmii_rx_consts.svh"
`default_nettype none

// Payload beats and end-of-frame info, framer to FCS checker
interface rx_beat_if;
	import rx_stream_pkg::*;

	logic						beat_valid;
	// Earliest byte in bits 7:0
	logic [`XGMII_DATA_W-1:0]	data;
	strb_t						strb;
	byte_count_t				crc_bytes;
	logic						crc_restart;
	logic						frame_end;
	// Received FCS, first wire byte in bits 7:0
	logic [`XGMII_DATA_W-1:0]	fcs;
	logic						abort;

	modport framer (
		output beat_valid, data, strb, crc_bytes, crc_restart, frame_end, fcs, abort
	);

	modport fcs_check (
		input beat_valid, data, strb, crc_bytes, crc_restart, frame_end, fcs, abort
	);

endinterface

`default_nettype wire

/* xgmii_lane_decoder.sv */
`include "xgmii_rx_consts.svh"
`default_nettype none

module xgmii_lane_decoder (
	input wire logic					xgmii_rx_clk,
	input wire logic					rst,
	input wire logic					in_valid,
	input wire xgmii_pkg::xgmii_word_t	in_word,
	rx_lane_if.decoder					lanes
);
	import xgmii_pkg::*;

	lane_mask_t	end_hit;
	lane_mask_t	error_hit;
	logic		start_hit;

	////////////////////////////////////////
	// Per-lane control character compare

	always_comb begin
		for (int i = 0; i < `XGMII_LANES; i++) begin
			// Only a control lane may carry a control code
			end_hit[i]		= in_word.ctl[i] && (in_word.data[8*i +: 8] == `XGMII_CTL_END);
			error_hit[i]	= in_word.ctl[i] && (in_word.data[8*i +: 8] == `XGMII_CTL_ERROR);
		end

		// Start is only legal in the leftmost lane
		start_hit = in_word.ctl[3] && (in_word.data[31:24] == `XGMII_CTL_START);
	end

	////////////////////////////////////////
	// Output register

	always_ff @(posedge xgmii_rx_clk) begin
		if (rst) begin
			lanes.valid			<= 1'b0;
			lanes.start_seen	<= 1'b0;
			lanes.end_lanes		<= '0;
			lanes.error_lanes	<= '0;
		end else begin
			lanes.valid			<= in_valid;
			lanes.start_seen	<= start_hit;
			lanes.end_lanes		<= end_hit;
			lanes.error_lanes	<= error_hit;
		end
	end

	// Raw word travels alongside its flags
	always_ff @(posedge xgmii_rx_clk) begin
		lanes.word <= in_word;
	end

endmodule

`default_nettype wire

/* rx_frame_fsm.sv */
`include "xgmii_rx_consts.svh"
`default_nettype none

module rx_frame_fsm (
	input wire logic	xgmii_rx_clk,
	input wire logic	rst,
	rx_lane_if.framer	lanes,
	rx_beat_if.framer	beats
);
	import rx_stream_pkg::*;

	frame_state_t					state;
	logic							last_was_preamble;
	// Word from the previous valid cycle, held back one word
	logic [`XGMII_DATA_W-1:0]		prev_data;
	logic [`XGMII_DATA_W-1:0]		prev_swap;
	logic [`XGMII_DATA_W-1:0]		cur_swap;
	logic [2*`XGMII_DATA_W-1:0]		tail_bytes;
	byte_count_t					tail_count;
	logic							preamble_ok;
	logic							abort_now;

	////////////////////////////////////////
	// Byte order and end-of-frame decode

	// Swap so the earliest wire byte sits in bits 7:0
	always_comb begin
		for (int i = 0; i < `XGMII_LANES; i++) begin
			prev_swap[8*i +: 8]	= prev_data[8*(`XGMII_LANES-1-i) +: 8];
			cur_swap[8*i +: 8]	= lanes.word.data[8*(`XGMII_LANES-1-i) +: 8];
		end
	end

	// Eight bytes in wire order, previous word first
	assign tail_bytes = {cur_swap, prev_swap};

	// Payload bytes left in the previous word, by terminate lane
	always_comb begin
		if (lanes.end_lanes[3]) begin
			tail_count = 3'd0;
		end else if (lanes.end_lanes[2]) begin
			tail_count = 3'd1;
		end else if (lanes.end_lanes[1]) begin
			tail_count = 3'd2;
		end else begin
			tail_count = 3'd3;
		end
	end

	assign preamble_ok	= (lanes.word.ctl == '0) && (lanes.word.data == `XGMII_PREAMBLE_SFD);
	// Error code anywhere in an active frame
	assign abort_now	= (|lanes.error_lanes) && (state != IDLE);

	////////////////////////////////////////
	// Frame state machine

	always_ff @(posedge xgmii_rx_clk) begin
		// Single-cycle strobes
		beats.beat_valid	<= 1'b0;
		beats.frame_end		<= 1'b0;
		beats.crc_restart	<= 1'b0;
		beats.abort			<= 1'b0;

		if (rst) begin
			state				<= IDLE;
			last_was_preamble	<= 1'b0;
		end else if (lanes.valid) begin
			last_was_preamble <= 1'b0;

			case (state)
				IDLE: begin
					if (lanes.start_seen) begin
						state <= PREAMBLE;
					end
				end

				PREAMBLE: begin
					beats.crc_restart <= 1'b1;
					// Bad second word drops the frame quietly
					if (preamble_ok) begin
						state				<= BODY;
						last_was_preamble	<= 1'b1;
					end else begin
						state <= IDLE;
					end
				end

				BODY: begin
					if (|lanes.end_lanes) begin
						// Lane 3 terminate leaves nothing but FCS in the previous word
						beats.beat_valid	<= (tail_count != 3'd0);
						beats.frame_end		<= 1'b1;
						state				<= IDLE;
					end else if (!last_was_preamble) begin
						beats.beat_valid <= 1'b1;
					end
				end

				default: begin
					state <= IDLE;
				end
			endcase

			// Error overrides everything else
			if (abort_now) begin
				state				<= IDLE;
				beats.beat_valid	<= 1'b0;
				beats.frame_end		<= 1'b0;
				beats.abort			<= 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Beat payload

	always_ff @(posedge xgmii_rx_clk) begin
		if (lanes.valid) begin
			prev_data	<= lanes.word.data;
			beats.data	<= prev_swap;
			// FCS starts right after the last payload byte
			beats.fcs	<= tail_bytes[{tail_count, 3'b000} +: `XGMII_DATA_W];

			if (|lanes.end_lanes) begin
				beats.strb		<= (strb_t'(1) << tail_count) - strb_t'(1);
				beats.crc_bytes	<= tail_count;
			end else begin
				beats.strb		<= '1;
				beats.crc_bytes	<= byte_count_t'(`XGMII_LANES);
			end
		end
	end

endmodule

`default_nettype wire

/* rx_crc32.sv */
`include "xgmii_rx_consts.svh"
`default_nettype none

module rx_crc32 (
	input wire logic						xgmii_rx_clk,
	input wire logic						rst,
	input wire logic						restart,
	input wire logic [`XGMII_DATA_W-1:0]	data,
	input wire rx_stream_pkg::byte_count_t	nbytes,
	output logic [`XGMII_DATA_W-1:0]		crc
);

	logic [31:0] crc_q;
	logic [31:0] crc_next;

	// One byte through the reflected LFSR, LSB first
	function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] b);
		logic [31:0] r;
		r = c ^ {24'h0, b};
		for (int i = 0; i < 8; i++) begin
			if (r[0]) begin
				r = (r >> 1) ^ `CRC32_POLY;
			end else begin
				r = r >> 1;
			end
		end
		return r;
	endfunction

	// Chain up to four bytes, earliest in bits 7:0
	always_comb begin
		crc_next = crc_q;
		for (int k = 0; k < `XGMII_LANES; k++) begin
			if (k < nbytes) begin
				crc_next = crc_byte(crc_next, data[8*k +: 8]);
			end
		end
	end

	always_ff @(posedge xgmii_rx_clk) begin
		if (rst || restart) begin
			crc_q <= `CRC32_INIT;
		end else begin
			crc_q <= crc_next;
		end
	end

	// Finished value, matches the FCS as sent LSB first
	assign crc = crc_q ^ `CRC32_XOROUT;

endmodule

`default_nettype wire

/* rx_fcs_checker.sv */
`include "xgmii_rx_consts.svh"
`default_nettype none

module rx_fcs_checker (
	input wire logic					xgmii_rx_clk,
	input wire logic					rst,
	rx_beat_if.fcs_check				beats,
	output logic						tvalid,
	output logic [`XGMII_DATA_W-1:0]	tdata,
	output logic [`XGMII_LANES-1:0]		tstrb,
	output logic						tlast,
	output logic						tuser
);
	import rx_stream_pkg::*;

	// One-entry hold for the newest beat
	logic						hold_valid;
	logic [`XGMII_DATA_W-1:0]	hold_data;
	strb_t						hold_strb;
	// Frame ended, waiting for the CRC to settle
	logic						end_pending;
	logic [`XGMII_DATA_W-1:0]	fcs_q;
	logic [`XGMII_DATA_W-1:0]	crc;
	byte_count_t				crc_nbytes;

	////////////////////////////////////////
	// CRC over payload beats

	assign crc_nbytes = beats.beat_valid ? beats.crc_bytes : byte_count_t'(0);

	rx_crc32 crc_inst (
		.xgmii_rx_clk	(xgmii_rx_clk),
		.rst			(rst),
		.restart		(beats.crc_restart),
		.data			(beats.data),
		.nbytes			(crc_nbytes),
		.crc			(crc)
	);

	////////////////////////////////////////
	// Release control

	always_ff @(posedge xgmii_rx_clk) begin
		tvalid	<= 1'b0;
		tlast	<= 1'b0;
		tuser	<= 1'b0;

		if (rst) begin
			hold_valid	<= 1'b0;
			end_pending	<= 1'b0;
		end else if (beats.abort) begin
			// Flush with error, empty beat if nothing held
			tvalid		<= 1'b1;
			tlast		<= 1'b1;
			tuser		<= 1'b1;
			hold_valid	<= 1'b0;
			end_pending	<= 1'b0;
		end else if (end_pending) begin
			// CRC now covers the last payload byte
			tvalid		<= 1'b1;
			tlast		<= 1'b1;
			tuser		<= (crc != fcs_q);
			hold_valid	<= 1'b0;
			end_pending	<= 1'b0;
		end else begin
			// New beat pushes the held one out
			if (beats.beat_valid) begin
				tvalid		<= hold_valid;
				hold_valid	<= 1'b1;
			end
			if (beats.frame_end) begin
				end_pending <= 1'b1;
			end
		end
	end

	// Data path of hold and output registers
	always_ff @(posedge xgmii_rx_clk) begin
		if (beats.beat_valid) begin
			hold_data	<= beats.data;
			hold_strb	<= beats.strb;
		end
		if (beats.frame_end) begin
			fcs_q <= beats.fcs;
		end
		tdata <= hold_data;
		tstrb <= hold_valid ? hold_strb : '0;
	end

endmodule

`default_nettype wire

/* xgmii_rx_mac.sv */
`include "xgmii_rx_consts.svh"
`default_nettype none

module xgmii_rx_mac (
	input wire logic						xgmii_rx_clk,
	input wire logic						rst,
	input wire logic						xgmii_rx_valid,
	input wire logic [`XGMII_DATA_W-1:0]	xgmii_rx_data,
	input wire logic [`XGMII_LANES-1:0]		xgmii_rx_ctl,
	output logic							rx_tvalid,
	output logic [`XGMII_DATA_W-1:0]		rx_tdata,
	output logic [`XGMII_LANES-1:0]			rx_tstrb,
	output logic							rx_tlast,
	output logic							rx_tuser
);
	import xgmii_pkg::*;

	xgmii_word_t in_word;

	rx_lane_if lanes_if ();
	rx_beat_if beats_if ();

	assign in_word = '{data: xgmii_rx_data, ctl: xgmii_rx_ctl};

	////////////////////////////////////////
	// Decode, frame, check

	xgmii_lane_decoder decoder_inst (
		.xgmii_rx_clk	(xgmii_rx_clk),
		.rst			(rst),
		.in_valid		(xgmii_rx_valid),
		.in_word		(in_word),
		.lanes			(lanes_if.decoder)
	);

	rx_frame_fsm framer_inst (
		.xgmii_rx_clk	(xgmii_rx_clk),
		.rst			(rst),
		.lanes			(lanes_if.framer),
		.beats			(beats_if.framer)
	);

	rx_fcs_checker checker_inst (
		.xgmii_rx_clk	(xgmii_rx_clk),
		.rst			(rst),
		.beats			(beats_if.fcs_check),
		.tvalid			(rx_tvalid),
		.tdata			(rx_tdata),
		.tstrb			(rx_tstrb),
		.tlast			(rx_tlast),
		.tuser			(rx_tuser)
	);

endmodule

`default_nettype wire

/* xgmii_rx_properties.sv */
`include "xgmii_rx_consts.svh"
`default_nettype none

module xgmii_rx_properties (
	input wire logic						xgmii_rx_clk,
	input wire logic						rst,
	input wire logic						rx_tvalid,
	input wire logic [`XGMII_LANES-1:0]		rx_tstrb,
	input wire logic						rx_tlast,
	input wire logic						rx_tuser
);
	timeunit 1ns;
	timeprecision 1ps;

	// Number of failed stream properties
	int fail_count = 0;

	////////////////////////////////////////
	// Output stream rules

	tlast_with_tvalid: assert property (@(posedge xgmii_rx_clk) disable iff (rst)
		rx_tlast |-> rx_tvalid)
		else begin
			$error("rx_tlast high without rx_tvalid");
			fail_count++;
		end

	tuser_with_tlast: assert property (@(posedge xgmii_rx_clk) disable iff (rst)
		rx_tuser |-> rx_tlast)
		else begin
			$error("rx_tuser high outside an rx_tlast beat");
			fail_count++;
		end

	// Strobes fill from bit 0 upward, empty only on an abort beat
	strb_contiguous: assert property (@(posedge xgmii_rx_clk) disable iff (rst)
		rx_tvalid |-> (rx_tstrb inside {4'b0000, 4'b0001, 4'b0011, 4'b0111, 4'b1111}))
		else begin
			$error("rx_tstrb %b not contiguous from bit 0", rx_tstrb);
			fail_count++;
		end

	// Output register clears one edge into reset
	quiet_in_reset: assert property (@(posedge xgmii_rx_clk)
		rst |=> !rx_tvalid)
		else begin
			$error("rx_tvalid high while in reset");
			fail_count++;
		end

endmodule

`default_nettype wire

/* tb_xgmii_rx_mac.sv */
`include "xgmii_rx_consts.svh"
`default_nettype none

module tb_xgmii_rx_mac;
	timeunit 1ns;
	timeprecision 1ps;

	logic							xgmii_rx_clk;
	logic							rst;
	logic							xgmii_rx_valid;
	logic [`XGMII_DATA_W-1:0]		xgmii_rx_data;
	logic [`XGMII_LANES-1:0]		xgmii_rx_ctl;
	logic							rx_tvalid;
	logic [`XGMII_DATA_W-1:0]		rx_tdata;
	logic [`XGMII_LANES-1:0]		rx_tstrb;
	logic							rx_tlast;
	logic							rx_tuser;

	// Expected frames, payload bytes flattened in send order
	logic [7:0]		exp_bytes[$];
	int				exp_len[$];
	logic			exp_tuser[$];
	// Aborted frame, only a prefix of the payload comes out
	logic			exp_cut[$];

	// Bytes of the frame now arriving at the output
	logic [7:0]		rx_bytes[$];

	int				seed = 93252;
	int				errors = 0;
	int				frames_checked = 0;
	int				words_sent = 0;
	int				cycles = 0;
	// Lengths mod 4 put the terminate in each of the four lanes
	int				good_lens[8] = '{8, 9, 10, 11, 17, 30, 47, 64};

	xgmii_rx_mac xgmii_rx_mac_inst (
		.xgmii_rx_clk	(xgmii_rx_clk),
		.rst			(rst),
		.xgmii_rx_valid	(xgmii_rx_valid),
		.xgmii_rx_data	(xgmii_rx_data),
		.xgmii_rx_ctl	(xgmii_rx_ctl),
		.rx_tvalid		(rx_tvalid),
		.rx_tdata		(rx_tdata),
		.rx_tstrb		(rx_tstrb),
		.rx_tlast		(rx_tlast),
		.rx_tuser		(rx_tuser)
	);

	bind xgmii_rx_mac xgmii_rx_properties props_inst (
		.xgmii_rx_clk	(xgmii_rx_clk),
		.rst			(rst),
		.rx_tvalid		(rx_tvalid),
		.rx_tstrb		(rx_tstrb),
		.rx_tlast		(rx_tlast),
		.rx_tuser		(rx_tuser)
	);

	initial begin
		xgmii_rx_clk = 1'b0;
		forever #2 xgmii_rx_clk = ~xgmii_rx_clk;
	end

	////////////////////////////////////////
	// Reference model

	// Ethernet CRC-32, bit-serial, each byte LSB first
	function automatic logic [31:0] ref_crc32(input logic [7:0] bytes_in[$]);
		logic [31:0]	c;
		logic			fb;
		c = `CRC32_INIT;
		foreach (bytes_in[i]) begin
			for (int b = 0; b < 8; b++) begin
				fb = c[0] ^ bytes_in[i][b];
				c = c >> 1;
				if (fb) begin
					c = c ^ `CRC32_POLY;
				end
			end
		end
		return c ^ `CRC32_XOROUT;
	endfunction

	////////////////////////////////////////
	// Stimulus

	task automatic drive_word(input logic [31:0] data, input logic [3:0] ctl);
		@(negedge xgmii_rx_clk);
		xgmii_rx_data = data;
		xgmii_rx_ctl = ctl;
		words_sent++;
	endtask

	// One frame plus two idle words
	// err_word of zero or more replaces that payload word with error codes
	task automatic send_frame(input int len, input bit bad_fcs, input bit bad_pre,
		input int err_word);
		logic [7:0]		payload[$];
		logic [8:0]		lane_q[$];
		logic [8:0]		ent;
		logic [7:0]		b;
		logic [31:0]	crc;
		logic [31:0]	d;
		logic [3:0]		c;
		for (int i = 0; i < len; i++) begin
			payload.push_back(8'($random(seed)));
		end
		crc = ref_crc32(payload);

		// Dropped frames leave no trace at the output
		if (!bad_pre) begin
			foreach (payload[i]) begin
				exp_bytes.push_back(payload[i]);
			end
			exp_len.push_back(len);
			exp_tuser.push_back(bad_fcs || (err_word >= 0));
			exp_cut.push_back(err_word >= 0);
		end

		// Lane stream of {ctl, byte}, FCS least significant byte first
		foreach (payload[i]) begin
			lane_q.push_back({1'b0, payload[i]});
		end
		for (int i = 0; i < 4; i++) begin
			b = crc[8*i +: 8];
			if (bad_fcs && (i == 1)) begin
				b = b ^ 8'h5a;
			end
			lane_q.push_back({1'b0, b});
		end
		lane_q.push_back({1'b1, `XGMII_CTL_END});
		while ((lane_q.size() % 4) != 0) begin
			lane_q.push_back({1'b1, `XGMII_CTL_IDLE});
		end

		drive_word({`XGMII_CTL_START, 24'h55_5555}, 4'b1000);
		drive_word(bad_pre ? 32'h5555_55d4 : `XGMII_PREAMBLE_SFD, 4'b0000);
		for (int w = 0; w < lane_q.size() / 4; w++) begin
			for (int k = 0; k < 4; k++) begin
				// Lane 3 carries the earliest byte
				ent = lane_q[4*w + k];
				d[8*(3-k) +: 8] = ent[7:0];
				c[3-k] = ent[8];
			end
			if (w == err_word) begin
				d = {4{`XGMII_CTL_ERROR}};
				c = 4'hf;
			end
			drive_word(d, c);
		end
		repeat (2) drive_word({4{`XGMII_CTL_IDLE}}, 4'hf);
	endtask

	task automatic wait_drain();
		while (exp_len.size() != 0) begin
			@(negedge xgmii_rx_clk);
		end
		// Room for stray beats to show
		repeat (6) @(negedge xgmii_rx_clk);
		assert (rx_bytes.size() == 0) else begin
			$display("%0d output bytes arrived after the last expected frame ended",
				rx_bytes.size());
			errors++;
			rx_bytes.delete();
		end
	endtask

	task automatic report_test(input int num, input string name, input int base);
		$display("test %0d %s: %0d errors, %s", num, name, errors - base,
			(errors == base) ? "ok" : "failed");
	endtask

	////////////////////////////////////////
	// Output monitor and compare

	task automatic check_frame();
		int			len;
		logic		tuser_exp;
		logic		cut;
		logic [7:0]	e;
		assert (exp_len.size() != 0) else begin
			$display("Output frame of %0d bytes arrived with no frame expected",
				rx_bytes.size());
			errors++;
		end
		if (exp_len.size() != 0) begin
			len = exp_len.pop_front();
			tuser_exp = exp_tuser.pop_front();
			cut = exp_cut.pop_front();
			if (cut) begin
				assert (rx_bytes.size() < len) else begin
					$display("Aborted frame %0d still delivered all %0d bytes",
						frames_checked, len);
					errors++;
				end
			end else begin
				assert (rx_bytes.size() == len) else begin
					$display("** Error: rx_tstrb byte count in frame %0d: expected %h, got %h",
						frames_checked, len, rx_bytes.size());
					errors++;
				end
			end
			for (int i = 0; i < len; i++) begin
				e = exp_bytes.pop_front();
				if (i < rx_bytes.size()) begin
					assert (rx_bytes[i] == e) else begin
						$display("** Error: rx_tdata byte %0d of frame %0d: expected %h, got %h",
							i, frames_checked, e, rx_bytes[i]);
						errors++;
					end
				end
			end
			assert (rx_tuser == tuser_exp) else begin
				$display("** Error: rx_tuser in frame %0d: expected %h, got %h",
					frames_checked, tuser_exp, rx_tuser);
				errors++;
			end
			frames_checked++;
		end
		rx_bytes.delete();
	endtask

	// Outputs settle after the rising edge, sample them mid-cycle
	always @(negedge xgmii_rx_clk) begin
		if (!rst && rx_tvalid) begin
			for (int i = 0; i < `XGMII_LANES; i++) begin
				if (rx_tstrb[i]) begin
					rx_bytes.push_back(rx_tdata[8*i +: 8]);
				end
			end
			if (rx_tlast) begin
				check_frame();
			end
		end
	end

	////////////////////////////////////////
	// Watchdog

	// Limit follows the words sent so far
	initial begin
		while (cycles <= words_sent + 200) begin
			@(posedge xgmii_rx_clk);
			cycles++;
		end
		$display("Timeout: output stalled after %0d cycles with %0d XGMII words sent",
			cycles, words_sent);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	////////////////////////////////////////
	// Test sequence

	initial begin
		int base;
		int len;
		rst = 1'b1;
		xgmii_rx_valid = 1'b1;
		xgmii_rx_data = {4{`XGMII_CTL_IDLE}};
		xgmii_rx_ctl = 4'hf;
		repeat (5) @(posedge xgmii_rx_clk);
		@(negedge xgmii_rx_clk);
		rst = 1'b0;

		base = errors;
		foreach (good_lens[i]) begin
			send_frame(good_lens[i], 1'b0, 1'b0, -1);
		end
		wait_drain();
		report_test(1, "good frames over all terminate lanes", base);

		base = errors;
		send_frame(20, 1'b1, 1'b0, -1);
		wait_drain();
		report_test(2, "corrupted FCS byte", base);

		// Error codes in the sixth payload word
		base = errors;
		send_frame(40, 1'b0, 1'b0, 5);
		wait_drain();
		report_test(3, "error code mid-payload", base);

		base = errors;
		send_frame(24, 1'b0, 1'b1, -1);
		send_frame(33, 1'b0, 1'b0, -1);
		wait_drain();
		report_test(4, "bad preamble then good frame", base);

		base = errors;
		for (int i = 0; i < 12; i++) begin
			len = 8 + ({$random(seed)} % 57);
			send_frame(len, 1'b0, 1'b0, -1);
		end
		wait_drain();
		report_test(5, "random burst at minimum gap", base);

		// Output stream rules from the bound property module
		assert (xgmii_rx_mac_inst.props_inst.fail_count == 0) else begin
			$display("Output stream properties failed %0d times during the run",
				xgmii_rx_mac_inst.props_inst.fail_count);
			errors++;
		end

		$display("Summary: %0d frames checked, %0d errors", frames_checked, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
xgmii_pkg.sv
rx_stream_pkg.sv
rx_lane_if.sv
rx_beat_if.sv
xgmii_lane_decoder.sv
rx_frame_fsm.sv
rx_crc32.sv
rx_fcs_checker.sv
xgmii_rx_mac.sv
xgmii_rx_properties.sv
tb_xgmii_rx_mac.sv

/* Bender.yml */
package:
  name: xgmii_rx_mac

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - xgmii_pkg.sv
      - rx_stream_pkg.sv
      - rx_lane_if.sv
      - rx_beat_if.sv
      - xgmii_lane_decoder.sv
      - rx_frame_fsm.sv
      - rx_crc32.sv
      - rx_fcs_checker.sv
      - xgmii_rx_mac.sv
  - target: test
    include_dirs:
      - .
    files:
      - xgmii_rx_properties.sv
      - tb_xgmii_rx_mac.sv
